// File: Makefile
SIM      ?= verilator
TOP      ?= recovery_handler_tb
FILELIST ?= files.f
FLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "All tests passed" > /dev/null

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/recovery_handler_tb.sv
// One fixed target address; the reader is held long enough to fill the FIFO and stall the executor
`timescale 1ns/1ps
`default_nettype none

module recovery_handler_tb;

  localparam int unsigned         WaitLimit   = 2000;
  localparam logic [16:0]         LfsrSeed    = 17'd97535;
  localparam recovery_pkg::byte_t NormalMode  = 8'h01;
  localparam recovery_pkg::byte_t TargetAddr  = 8'hD2;
  localparam recovery_pkg::byte_t UnknownCode = 8'h55;

  logic                clk;
  logic                arst_n;
  recovery_pkg::byte_t mode;
  logic                bus_start;
  logic                bus_stop;
  recovery_pkg::byte_t bus_addr;
  logic                bus_addr_valid;
  logic                ctl_valid;
  recovery_pkg::byte_t ctl_data;
  logic                ctl_ready;
  logic                tti_valid;
  recovery_pkg::byte_t tti_data;
  logic                tti_ready;
  logic                pay_valid;
  recovery_pkg::byte_t pay_data;
  logic                pay_ready;
  logic                pay_avail;
  logic                image;
  recovery_pkg::byte_t err_count;

  logic [16:0]         lfsr_q;
  recovery_pkg::byte_t pkt_data[$];
  recovery_pkg::byte_t exp_payload[$];
  recovery_pkg::byte_t exp_tti[$];
  recovery_pkg::byte_t exp_errors;
  logic                exp_image;
  int unsigned         errors;
  int unsigned         payload_count;
  int unsigned         tti_count;

  tb_clk_gen clk_gen_inst (
    .clk_o   (clk),
    .arst_n_o(arst_n)
  );

  recovery_handler recovery_handler_inst (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .mode_i             (mode),
    .bus_start_i        (bus_start),
    .bus_stop_i         (bus_stop),
    .bus_addr_i         (bus_addr),
    .bus_addr_valid_i   (bus_addr_valid),
    .ctl_rx_valid_i     (ctl_valid),
    .ctl_rx_data_i      (ctl_data),
    .ctl_rx_ready_o     (ctl_ready),
    .tti_rx_valid_o     (tti_valid),
    .tti_rx_data_o      (tti_data),
    .tti_rx_ready_i     (tti_ready),
    .payload_valid_o    (pay_valid),
    .payload_data_o     (pay_data),
    .payload_ready_i    (pay_ready),
    .payload_available_o(pay_avail),
    .image_activated_o  (image),
    .error_count_o      (err_count)
  );

  // x^17 + x^14 + 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_q[16] ^ lfsr_q[13];
    lfsr_q = {lfsr_q[15:0], fb};
    return fb;
  endfunction

  function automatic int unsigned rand_bits(int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      v = (v << 1) | {31'd0, lfsr_next_bit()};
    end
    return v;
  endfunction

  // Bitwise SMBus CRC-8 over the address byte, then the packet bytes
  function automatic recovery_pkg::byte_t pec_ref(recovery_pkg::byte_t addr,
                                                  recovery_pkg::byte_t data[$]);
    recovery_pkg::byte_t crc;
    recovery_pkg::byte_t cur;
    logic                fb;
    crc = 8'h00;
    for (int i = 0; i <= data.size(); i++) begin
      cur = (i == 0) ? addr : data[i - 1];
      for (int b = 7; b >= 0; b--) begin
        fb = crc[7] ^ cur[b];
        crc = {crc[6:0], 1'b0};
        if (fb) begin
          crc = crc ^ 8'h07;
        end
      end
    end
    return crc;
  endfunction

  task automatic finish_run();
    $display("payload bytes %0d, pass-through bytes %0d, errors %0d",
             payload_count, tti_count, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(string what);
    errors++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic report_value(string name, recovery_pkg::byte_t got,
                              recovery_pkg::byte_t exp);
    errors++;
    $display("error %s: got 0x%02h, expected 0x%02h", name, got, exp);
  endtask

  task automatic make_payload(int unsigned len);
    pkt_data.delete();
    for (int unsigned i = 0; i < len; i++) begin
      pkt_data.push_back(recovery_pkg::byte_t'(rand_bits(8)));
    end
  endtask

  task automatic send_byte(recovery_pkg::byte_t b);
    int unsigned waited;
    waited = 0;
    ctl_valid = 1'b1;
    ctl_data = b;
    @(posedge clk);
    while (!ctl_ready) begin
      if (waited == WaitLimit) begin
        stop_on_timeout("ctl_rx_ready_o");
      end
      waited++;
      @(posedge clk);
    end
    @(negedge clk);
    ctl_valid = 1'b0;
  endtask

  task automatic wait_receiver_ready();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!ctl_ready) begin
      if (waited == WaitLimit) begin
        stop_on_timeout("the receiver to finish a command");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  // Framing: start, address, cmd, length LSB first, payload, PEC, stop
  task automatic send_packet(recovery_pkg::byte_t code, recovery_pkg::len_t len,
                             recovery_pkg::byte_t pec_flip);
    recovery_pkg::byte_t body[$];
    recovery_pkg::byte_t pec;
    body.delete();
    body.push_back(code);
    body.push_back(len[7:0]);
    body.push_back(len[15:8]);
    foreach (pkt_data[i]) begin
      body.push_back(pkt_data[i]);
    end
    pec = pec_ref(TargetAddr, body) ^ pec_flip;
    bus_start = 1'b1;
    @(negedge clk);
    bus_start = 1'b0;
    bus_addr = TargetAddr;
    bus_addr_valid = 1'b1;
    @(negedge clk);
    bus_addr_valid = 1'b0;
    foreach (body[i]) begin
      send_byte(body[i]);
    end
    send_byte(pec);
    bus_stop = 1'b1;
    @(negedge clk);
    bus_stop = 1'b0;
    wait_receiver_ready();
  endtask

  task automatic indirect_packet(int unsigned len);
    make_payload(len);
    foreach (pkt_data[i]) begin
      exp_payload.push_back(pkt_data[i]);
    end
    send_packet(recovery_pkg::INDIRECT_DATA, recovery_pkg::len_t'(len), 8'h00);
  endtask

  // Only valid once the executor has finished the last command
  task automatic check_status();
    if (err_count !== exp_errors) begin
      report_value("error_count_o", err_count, exp_errors);
    end
    if (image !== exp_image) begin
      report_value("image_activated_o", recovery_pkg::byte_t'(image),
                   recovery_pkg::byte_t'(exp_image));
    end
    if (pay_avail !== (exp_payload.size() != 0)) begin
      report_value("payload_available_o", recovery_pkg::byte_t'(pay_avail),
                   recovery_pkg::byte_t'(exp_payload.size() != 0));
    end
  endtask

  task automatic wait_payload_drained();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (exp_payload.size() != 0) begin
      if (waited == WaitLimit) begin
        stop_on_timeout("the payload FIFO to drain");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic pass_through(int unsigned n);
    recovery_pkg::byte_t b;
    for (int unsigned i = 0; i < n; i++) begin
      b = recovery_pkg::byte_t'(rand_bits(8));
      exp_tti.push_back(b);
      send_byte(b);
      if (lfsr_next_bit()) begin
        @(negedge clk);
      end
    end
    if (exp_tti.size() != 0) begin
      errors++;
      $display("%0d pass-through bytes never appeared on tti_rx_*", exp_tti.size());
    end
  endtask

  // ctl_rx_ready_o follows the receiver only once the mode has switched
  task automatic enter_recovery();
    int unsigned waited;
    waited = 0;
    tti_ready = 1'b0;
    mode = recovery_pkg::RecoveryModeValue;
    @(negedge clk);
    while (!ctl_ready) begin
      if (waited == WaitLimit) begin
        stop_on_timeout("recovery mode to take effect");
      end
      waited++;
      @(negedge clk);
    end
    tti_ready = 1'b1;
  endtask

  always @(posedge clk) begin
    if (arst_n && tti_valid && tti_ready) begin
      if (exp_tti.size() == 0) begin
        errors++;
        $display("tti_rx_data_o carried 0x%02h with no byte expected", tti_data);
      end else begin
        if (tti_data !== exp_tti[0]) begin
          report_value("tti_rx_data_o", tti_data, exp_tti[0]);
        end
        void'(exp_tti.pop_front());
        tti_count++;
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n && pay_valid && pay_ready) begin
      if (exp_payload.size() == 0) begin
        errors++;
        $display("payload_data_o gave 0x%02h with no byte expected", pay_data);
      end else begin
        if (pay_data !== exp_payload[0]) begin
          report_value("payload_data_o", pay_data, exp_payload[0]);
        end
        void'(exp_payload.pop_front());
        payload_count++;
      end
    end
  end

  initial begin
    int unsigned waited;
    mode = NormalMode;
    bus_start = 1'b0;
    bus_stop = 1'b0;
    bus_addr = 8'h00;
    bus_addr_valid = 1'b0;
    ctl_valid = 1'b0;
    ctl_data = 8'h00;
    tti_ready = 1'b1;
    pay_ready = 1'b1;
    lfsr_q = LfsrSeed;
    exp_errors = 8'h00;
    exp_image = 1'b0;
    errors = 0;
    payload_count = 0;
    tti_count = 0;
    waited = 0;
    @(posedge clk);
    while (arst_n !== 1'b1) begin
      if (waited == WaitLimit) begin
        stop_on_timeout("reset release");
      end
      waited++;
      @(posedge clk);
    end
    @(negedge clk);

    // Normal mode pass-through
    pass_through(24);
    check_status();

    // Good INDIRECT_DATA packets with the reader running
    enter_recovery();
    for (int p = 0; p < 6; p++) begin
      indirect_packet(1 + rand_bits(4));
      check_status();
    end
    wait_payload_drained();
    check_status();

    // Bad packets, no payload expected
    make_payload(1 + rand_bits(4));
    send_packet(recovery_pkg::INDIRECT_DATA, recovery_pkg::len_t'(pkt_data.size()), 8'hFF);
    exp_errors = exp_errors + 8'd1;
    check_status();
    make_payload(4);
    send_packet(UnknownCode, 16'd4, 8'h00);
    exp_errors = exp_errors + 8'd1;
    check_status();
    make_payload(17);
    send_packet(recovery_pkg::INDIRECT_DATA, 16'd17, 8'h00);
    exp_errors = exp_errors + 8'd1;
    check_status();
    make_payload(2);
    send_packet(recovery_pkg::RECOVERY_CTRL, 16'd2, 8'h00);
    exp_errors = exp_errors + 8'd1;
    check_status();

    // Image activation
    make_payload(3);
    pkt_data[2] = 8'h0E;
    send_packet(recovery_pkg::RECOVERY_CTRL, 16'd3, 8'h00);
    check_status();
    pkt_data[2] = recovery_pkg::ActivateImageValue;
    send_packet(recovery_pkg::RECOVERY_CTRL, 16'd3, 8'h00);
    exp_image = 1'b1;
    check_status();

    // Reader held past a full FIFO, at least 18 bytes queued
    pay_ready = 1'b0;
    fork
      begin
        repeat (300) @(negedge clk);
        pay_ready = 1'b1;
      end
    join_none
    for (int p = 0; p < 3; p++) begin
      indirect_packet(6 + rand_bits(2));
      check_status();
    end
    wait_payload_drained();
    check_status();

    // Leave recovery with bytes still in the FIFO
    pay_ready = 1'b0;
    indirect_packet(1 + rand_bits(3));
    check_status();
    mode = NormalMode;
    waited = 0;
    @(negedge clk);
    while (pay_avail) begin
      if (waited == WaitLimit) begin
        stop_on_timeout("the FIFO flush on leaving recovery");
      end
      waited++;
      @(negedge clk);
    end
    exp_payload.delete();
    exp_image = 1'b0;
    check_status();
    pay_ready = 1'b1;
    pass_through(16);
    check_status();

    finish_run();
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// Free-running 8 ns clock; reset is released on a falling edge after eight rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: files.f
src/recovery_pkg.sv
src/recovery_cmd_if.sv
src/recovery_pec.sv
src/recovery_rx_mux.sv
src/recovery_receiver.sv
src/recovery_executor.sv
src/recovery_handler.sv
dv/tb_clk_gen.sv
dv/recovery_handler_tb.sv

// File: src/recovery_cmd_if.sv
// Buffer reads are only valid while cmd_valid is high; rd_ack follows rd_req by one cycle
`timescale 1ns/1ps
`default_nettype none

interface recovery_cmd_if;

  logic                                  cmd_valid;
  recovery_pkg::recovery_cmd_e           cmd_code;
  recovery_pkg::len_t                    cmd_len;
  logic                                  cmd_error;
  logic                                  cmd_done;

  logic                                  rd_req;
  logic [recovery_pkg::PayloadAddrW-1:0] rd_idx;
  logic                                  rd_ack;
  recovery_pkg::byte_t                   rd_data;

  modport receiver(
    output cmd_valid, cmd_code, cmd_len, cmd_error, rd_ack, rd_data,
    input cmd_done, rd_req, rd_idx
  );

  modport executor(
    input cmd_valid, cmd_code, cmd_len, cmd_error, rd_ack, rd_data,
    output cmd_done, rd_req, rd_idx
  );

endinterface

`default_nettype wire

// File: src/recovery_executor.sv
// Error count saturates at 255 and is kept across mode changes; image flag is set-only
`timescale 1ns/1ps
`default_nettype none

module recovery_executor (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                enable_i,
  recovery_cmd_if.executor    cmd,
  output logic                payload_valid_o,
  output recovery_pkg::byte_t payload_data_o,
  input  logic                payload_ready_i,
  output logic                payload_available_o,
  output logic                image_activated_o,
  output recovery_pkg::byte_t error_count_o
);

  typedef enum logic [2:0] {
    EX_IDLE,
    EX_REQ,
    EX_ACK,
    EX_PUSH,
    EX_DONE
  } exec_state_e;

  typedef logic [recovery_pkg::PayloadFifoAddrW:0] ptr_t;

  exec_state_e                           state_q;
  logic [recovery_pkg::PayloadAddrW-1:0] idx_q;
  logic                                  err_q;
  logic                                  act_q;
  recovery_pkg::byte_t                   hold_q;

  recovery_pkg::byte_t                   fifo_mem[recovery_pkg::PayloadFifoDepth];
  ptr_t                                  wr_ptr_q;
  ptr_t                                  rd_ptr_q;
  logic                                  fifo_full;
  logic                                  fifo_empty;
  logic                                  push;
  logic                                  pop;
  recovery_pkg::byte_t                   push_data;
  logic                                  is_ctrl;
  logic                                  last;

  assign is_ctrl = (cmd.cmd_code == recovery_pkg::RECOVERY_CTRL);
  assign last    = (recovery_pkg::len_t'(idx_q) + 16'd1 == cmd.cmd_len);

  assign cmd.cmd_done = (state_q == EX_DONE);
  assign cmd.rd_req   = (state_q == EX_REQ);
  assign cmd.rd_idx   = idx_q;

  assign fifo_empty = (wr_ptr_q == rd_ptr_q);
  assign fifo_full  = (wr_ptr_q == {~rd_ptr_q[recovery_pkg::PayloadFifoAddrW],
                                    rd_ptr_q[recovery_pkg::PayloadFifoAddrW-1:0]});

  // Push straight from the read data, or from the hold register after a stall
  assign push = !fifo_full && !is_ctrl &&
                ((state_q == EX_ACK && cmd.rd_ack) || state_q == EX_PUSH);
  assign push_data = (state_q == EX_PUSH) ? hold_q : cmd.rd_data;
  assign pop = payload_valid_o && payload_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q           <= EX_IDLE;
      idx_q             <= '0;
      err_q             <= 1'b0;
      act_q             <= 1'b0;
      image_activated_o <= 1'b0;
    end else if (!enable_i) begin
      state_q           <= EX_IDLE;
      idx_q             <= '0;
      err_q             <= 1'b0;
      act_q             <= 1'b0;
      image_activated_o <= 1'b0;
    end else begin
      case (state_q)
        EX_IDLE: begin
          if (cmd.cmd_valid) begin
            idx_q <= '0;
            err_q <= 1'b0;
            act_q <= 1'b0;
            if (cmd.cmd_error || (is_ctrl && cmd.cmd_len != recovery_pkg::RecoveryCtrlLen)) begin
              err_q   <= 1'b1;
              state_q <= EX_DONE;
            end else if (is_ctrl) begin
              idx_q   <= recovery_pkg::PayloadAddrW'(recovery_pkg::RecoveryCtrlActIdx);
              state_q <= EX_REQ;
            end else if (cmd.cmd_len == '0) begin
              state_q <= EX_DONE;
            end else begin
              state_q <= EX_REQ;
            end
          end
        end
        EX_REQ: state_q <= EX_ACK;
        EX_ACK: begin
          if (cmd.rd_ack) begin
            if (is_ctrl) begin
              act_q   <= (cmd.rd_data == recovery_pkg::ActivateImageValue);
              state_q <= EX_DONE;
            end else if (fifo_full) begin
              state_q <= EX_PUSH;
            end else if (last) begin
              state_q <= EX_DONE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= EX_REQ;
            end
          end
        end
        EX_PUSH: begin
          if (!fifo_full) begin
            if (last) begin
              state_q <= EX_DONE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= EX_REQ;
            end
          end
        end
        EX_DONE: begin
          state_q <= EX_IDLE;
          if (act_q) begin
            image_activated_o <= 1'b1;
          end
        end
        default: state_q <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      error_count_o <= '0;
    end else if (enable_i && state_q == EX_DONE && err_q && error_count_o != 8'hFF) begin
      error_count_o <= error_count_o + 8'd1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (!enable_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == EX_ACK) begin
      hold_q <= cmd.rd_data;
    end
    if (push) begin
      fifo_mem[wr_ptr_q[recovery_pkg::PayloadFifoAddrW-1:0]] <= push_data;
    end
  end

  assign payload_valid_o     = !fifo_empty;
  assign payload_available_o = !fifo_empty;
  assign payload_data_o      = fifo_mem[rd_ptr_q[recovery_pkg::PayloadFifoAddrW-1:0]];

  // Occupancy never exceeds the depth, so no push ever lands on a full FIFO
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ptr_t'(wr_ptr_q - rd_ptr_q) <= ptr_t'(recovery_pkg::PayloadFifoDepth));

endmodule

`default_nettype wire

// File: src/recovery_handler.sv
// Write direction only; mode_i is sampled each cycle and leaving recovery flushes all state
`timescale 1ns/1ps
`default_nettype none

module recovery_handler (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  recovery_pkg::byte_t mode_i,

  // Bus conditions and address byte
  input  logic                bus_start_i,
  input  logic                bus_stop_i,
  input  recovery_pkg::byte_t bus_addr_i,
  input  logic                bus_addr_valid_i,

  input  logic                ctl_rx_valid_i,
  input  recovery_pkg::byte_t ctl_rx_data_i,
  output logic                ctl_rx_ready_o,

  output logic                tti_rx_valid_o,
  output recovery_pkg::byte_t tti_rx_data_o,
  input  logic                tti_rx_ready_i,

  // Firmware-side payload reader
  output logic                payload_valid_o,
  output recovery_pkg::byte_t payload_data_o,
  input  logic                payload_ready_i,
  output logic                payload_available_o,

  output logic                image_activated_o,
  output recovery_pkg::byte_t error_count_o
);

  logic                recovery_enable;
  logic                rec_valid;
  logic                rec_ready;
  recovery_pkg::byte_t rec_data;

  recovery_cmd_if cmd_if ();

  recovery_rx_mux rx_mux_inst (
    .clk_i,
    .arst_n_i,
    .mode_i,
    .ctl_rx_valid_i,
    .ctl_rx_data_i,
    .ctl_rx_ready_o,
    .tti_rx_valid_o,
    .tti_rx_data_o,
    .tti_rx_ready_i,
    .rec_valid_o      (rec_valid),
    .rec_data_o       (rec_data),
    .rec_ready_i      (rec_ready),
    .recovery_enable_o(recovery_enable)
  );

  recovery_receiver receiver_inst (
    .clk_i,
    .arst_n_i,
    .enable_i        (recovery_enable),
    .bus_start_i,
    .bus_stop_i,
    .bus_addr_i,
    .bus_addr_valid_i,
    .byte_valid_i    (rec_valid),
    .byte_data_i     (rec_data),
    .byte_ready_o    (rec_ready),
    .cmd             (cmd_if.receiver)
  );

  recovery_executor executor_inst (
    .clk_i,
    .arst_n_i,
    .enable_i(recovery_enable),
    .cmd     (cmd_if.executor),
    .payload_valid_o,
    .payload_data_o,
    .payload_ready_i,
    .payload_available_o,
    .image_activated_o,
    .error_count_o
  );

endmodule

`default_nettype wire

// File: src/recovery_pec.sv
// One byte per cycle, MSB first, no final XOR; clear_i wins over init_i and valid_i
`timescale 1ns/1ps
`default_nettype none

module recovery_pec (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clear_i,
  input  logic                valid_i,
  input  logic                init_i,
  input  recovery_pkg::byte_t data_i,
  output recovery_pkg::byte_t crc_o
);

  recovery_pkg::byte_t crc_q;

  function automatic recovery_pkg::byte_t crc8_step(recovery_pkg::byte_t crc,
                                                    recovery_pkg::byte_t data);
    recovery_pkg::byte_t c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = {c[6:0], 1'b0} ^ (c[7] ? recovery_pkg::PecPoly : 8'h00);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (valid_i && init_i) begin
      // Address byte restarts the checksum
      crc_q <= crc8_step(8'h00, data_i);
    end else if (valid_i) begin
      crc_q <= crc8_step(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

endmodule

`default_nettype wire

// File: src/recovery_pkg.sv
// Sizes are fixed here for the whole design; payload and FIFO depths must stay powers of two
`default_nettype none

package recovery_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] len_t;

  // Device-status mode byte that selects recovery
  localparam byte_t RecoveryModeValue = 8'h03;

  localparam int unsigned PayloadMax = 16;
  localparam int unsigned PayloadAddrW = $clog2(PayloadMax);
  localparam int unsigned PayloadFifoDepth = 16;
  localparam int unsigned PayloadFifoAddrW = $clog2(PayloadFifoDepth);

  // RECOVERY_CTRL is three bytes long, byte 2 carries the activation request
  localparam len_t RecoveryCtrlLen = 16'd3;
  localparam int unsigned RecoveryCtrlActIdx = 2;
  localparam byte_t ActivateImageValue = 8'h0F;

  // SMBus PEC polynomial x^8 + x^2 + x + 1
  localparam byte_t PecPoly = 8'h07;

  typedef enum logic [7:0] {
    RECOVERY_CTRL = 8'h26,
    INDIRECT_DATA = 8'h2B
  } recovery_cmd_e;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    LEN_LO,
    LEN_HI,
    DATA,
    PEC,
    DONE_WAIT,
    DISCARD
  } rx_state_e;

endpackage

`default_nettype wire

// File: src/recovery_receiver.sv
// Last byte before stop is taken as PEC; payloads above PayloadMax are dropped and flagged
`timescale 1ns/1ps
`default_nettype none

module recovery_receiver (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                enable_i,
  input  logic                bus_start_i,
  input  logic                bus_stop_i,
  input  recovery_pkg::byte_t bus_addr_i,
  input  logic                bus_addr_valid_i,
  input  logic                byte_valid_i,
  input  recovery_pkg::byte_t byte_data_i,
  output logic                byte_ready_o,
  recovery_cmd_if.receiver    cmd
);

  typedef logic [recovery_pkg::PayloadAddrW:0] cnt_t;

  recovery_pkg::rx_state_e state_q;
  recovery_pkg::byte_t     cmd_q;
  recovery_pkg::len_t      len_q;
  recovery_pkg::byte_t     pend_q;
  recovery_pkg::byte_t     buf_q[recovery_pkg::PayloadMax];
  cnt_t                    count_q;
  logic                    start_pend_q;

  logic                    byte_fire;
  logic                    buf_full;
  logic                    store;
  logic                    hdr_byte;
  logic                    pkt_error;
  logic                    pec_clear;
  logic                    pec_valid;
  recovery_pkg::byte_t     pec_data;
  recovery_pkg::byte_t     pec_crc;

  // Bus conditions take the cycle, so no byte is taken with them
  assign byte_ready_o = enable_i && (state_q != recovery_pkg::DONE_WAIT) &&
                        !bus_start_i && !bus_stop_i;
  assign byte_fire = byte_valid_i && byte_ready_o;
  assign buf_full  = (count_q == cnt_t'(recovery_pkg::PayloadMax));
  assign hdr_byte  = (state_q == recovery_pkg::CMD) || (state_q == recovery_pkg::LEN_LO) ||
                     (state_q == recovery_pkg::LEN_HI);

  // Held byte becomes payload once a later byte shows it was not the PEC
  assign store = byte_fire && (state_q == recovery_pkg::PEC) && !buf_full;

  assign pkt_error = (state_q == recovery_pkg::DISCARD) ||
                     (pend_q != pec_crc) ||
                     (len_q > recovery_pkg::len_t'(recovery_pkg::PayloadMax)) ||
                     (len_q != recovery_pkg::len_t'(count_q)) ||
                     !((cmd_q == recovery_pkg::RECOVERY_CTRL) ||
                       (cmd_q == recovery_pkg::INDIRECT_DATA));

  always_comb begin
    pec_clear = !enable_i || (bus_start_i && !bus_addr_valid_i);
    pec_valid = bus_addr_valid_i || (byte_fire && hdr_byte) || store;
    if (bus_addr_valid_i) begin
      pec_data = bus_addr_i;
    end else begin
      pec_data = (state_q == recovery_pkg::PEC) ? pend_q : byte_data_i;
    end
  end

  recovery_pec pec_inst (
    .clk_i,
    .arst_n_i,
    .clear_i(pec_clear),
    .valid_i(pec_valid),
    .init_i (bus_addr_valid_i),
    .data_i (pec_data),
    .crc_o  (pec_crc)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= recovery_pkg::IDLE;
      count_q       <= '0;
      start_pend_q  <= 1'b0;
      cmd.cmd_valid <= 1'b0;
      cmd.cmd_error <= 1'b0;
      cmd.rd_ack    <= 1'b0;
    end else if (!enable_i) begin
      state_q       <= recovery_pkg::IDLE;
      count_q       <= '0;
      start_pend_q  <= 1'b0;
      cmd.cmd_valid <= 1'b0;
      cmd.cmd_error <= 1'b0;
      cmd.rd_ack    <= 1'b0;
    end else begin
      cmd.rd_ack <= cmd.rd_req;
      if (state_q == recovery_pkg::DONE_WAIT) begin
        // A start seen while the command runs opens the next packet
        if (bus_start_i) begin
          start_pend_q <= 1'b1;
        end
        if (cmd.cmd_done) begin
          cmd.cmd_valid <= 1'b0;
          start_pend_q  <= 1'b0;
          count_q       <= '0;
          state_q       <= (start_pend_q || bus_start_i) ? recovery_pkg::CMD : recovery_pkg::IDLE;
        end
      end else if (bus_start_i) begin
        state_q <= recovery_pkg::CMD;
        count_q <= '0;
      end else if (bus_stop_i) begin
        if (state_q == recovery_pkg::PEC || state_q == recovery_pkg::DISCARD) begin
          state_q       <= recovery_pkg::DONE_WAIT;
          cmd.cmd_valid <= 1'b1;
          cmd.cmd_error <= pkt_error;
        end else begin
          state_q <= recovery_pkg::IDLE;
        end
      end else if (byte_fire) begin
        case (state_q)
          recovery_pkg::CMD:    state_q <= recovery_pkg::LEN_LO;
          recovery_pkg::LEN_LO: state_q <= recovery_pkg::LEN_HI;
          recovery_pkg::LEN_HI: state_q <= recovery_pkg::DATA;
          recovery_pkg::DATA:   state_q <= recovery_pkg::PEC;
          recovery_pkg::PEC: begin
            if (buf_full) begin
              state_q <= recovery_pkg::DISCARD;
            end else begin
              count_q <= count_q + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_fire) begin
      case (state_q)
        recovery_pkg::CMD:    cmd_q <= byte_data_i;
        recovery_pkg::LEN_LO: len_q[7:0] <= byte_data_i;
        recovery_pkg::LEN_HI: len_q[15:8] <= byte_data_i;
        recovery_pkg::DATA, recovery_pkg::PEC: pend_q <= byte_data_i;
        default: ;
      endcase
    end
    if (store) begin
      buf_q[count_q[recovery_pkg::PayloadAddrW-1:0]] <= pend_q;
    end
    cmd.rd_data <= buf_q[cmd.rd_idx];
  end

  assign cmd.cmd_code = recovery_pkg::recovery_cmd_e'(cmd_q);
  assign cmd.cmd_len  = len_q;

  a_cmd_held : assert property (@(posedge clk_i) disable iff (!arst_n_i || !enable_i)
    cmd.cmd_valid && !cmd.cmd_done |=> cmd.cmd_valid);

endmodule

`default_nettype wire

// File: src/recovery_rx_mux.sv
// Mode compare is registered, so a mode change takes effect one cycle later
`timescale 1ns/1ps
`default_nettype none

module recovery_rx_mux (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  recovery_pkg::byte_t mode_i,

  input  logic                ctl_rx_valid_i,
  input  recovery_pkg::byte_t ctl_rx_data_i,
  output logic                ctl_rx_ready_o,

  output logic                tti_rx_valid_o,
  output recovery_pkg::byte_t tti_rx_data_o,
  input  logic                tti_rx_ready_i,

  output logic                rec_valid_o,
  output recovery_pkg::byte_t rec_data_o,
  input  logic                rec_ready_i,

  output logic                recovery_enable_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      recovery_enable_o <= 1'b0;
    end else begin
      recovery_enable_o <= (mode_i == recovery_pkg::RecoveryModeValue);
    end
  end

  // Only the handshake is steered, both sides see the same data
  always_comb begin
    tti_rx_valid_o = ctl_rx_valid_i & ~recovery_enable_o;
    rec_valid_o    = ctl_rx_valid_i & recovery_enable_o;
    ctl_rx_ready_o = recovery_enable_o ? rec_ready_i : tti_rx_ready_i;
  end

  assign tti_rx_data_o = ctl_rx_data_i;
  assign rec_data_o    = ctl_rx_data_i;

  a_one_sink : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(tti_rx_valid_o && rec_valid_o));

endmodule

`default_nettype wire
